/* verilog/secv_pkg.sv */
// Core-wide definitions
package secv_pkg;

    // Register width of the core
    localparam int XLEN = 32;

    // Operations of one CSR request
    typedef enum logic [2:0] {
        OP_READ      = 3'd0,
        OP_WRITE     = 3'd1,     // Write, answer is the old value
        OP_EXCEPTION = 3'd2,
        OP_INTERRUPT = 3'd3,
        OP_MRET      = 3'd4
    } csr_op_t;

    // Synchronous exception causes
    typedef enum logic [3:0] {
        EX_CAUSE_INSTR_MISALIGNED   = 4'd0,
        EX_CAUSE_ILLEGAL_INSTR      = 4'd2,
        EX_CAUSE_BREAKPOINT         = 4'd3,
        EX_CAUSE_LOAD_MISALIGNED    = 4'd4,
        EX_CAUSE_LOAD_ACCESS_FAULT  = 4'd5,
        EX_CAUSE_STORE_MISALIGNED   = 4'd6,
        EX_CAUSE_STORE_ACCESS_FAULT = 4'd7,
        EX_CAUSE_ECALL_M            = 4'd11
    } ex_cause_t;

    // Machine-level interrupt causes
    typedef enum logic [3:0] {
        INTR_CAUSE_SOFTWARE = 4'd3,
        INTR_CAUSE_TIMER    = 4'd7,
        INTR_CAUSE_EXTERNAL = 4'd11
    } intr_cause_t;

endpackage

/* verilog/csr_pkg.sv */
// Machine CSR definitions
package csr_pkg;

    import secv_pkg::*;

    typedef logic [11:0] csr_adr_t;

    // Machine trap setup
    localparam csr_adr_t CSR_ADR_MSTATUS   = 12'h300;
    localparam csr_adr_t CSR_ADR_MISA      = 12'h301;
    localparam csr_adr_t CSR_ADR_MIE       = 12'h304;
    localparam csr_adr_t CSR_ADR_MTVEC     = 12'h305;

    // Machine trap handling
    localparam csr_adr_t CSR_ADR_MSCRATCH  = 12'h340;
    localparam csr_adr_t CSR_ADR_MEPC      = 12'h341;
    localparam csr_adr_t CSR_ADR_MCAUSE    = 12'h342;
    localparam csr_adr_t CSR_ADR_MTVAL     = 12'h343;

    // Machine information, read only
    localparam csr_adr_t CSR_ADR_MVENDORID = 12'hF11;
    localparam csr_adr_t CSR_ADR_MARCHID   = 12'hF12;
    localparam csr_adr_t CSR_ADR_MIMPID    = 12'hF13;
    localparam csr_adr_t CSR_ADR_MHARTID   = 12'hF14;

    localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_0088;  // MIE and MPIE
    localparam logic [XLEN-1:0] MIE_MASK     = 32'h0000_0888;  // MSIE, MTIE, MEIE
    localparam logic [XLEN-1:0] MTVEC_MASK   = 32'hFFFF_FFFD;  // Mode bit 1 reserved

    localparam logic [XLEN-1:0] MVENDORID  = 32'h0000_0000;  // Non-commercial
    localparam logic [XLEN-1:0] MARCHID    = 32'h0000_5EC5;
    localparam logic [XLEN-1:0] MIMPID     = 32'h0000_0100;
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100;  // MXL 32, I extension

    localparam logic [1:0] MSTATUS_MPP_M = 2'b11;

    typedef struct packed {
        logic [18:0] rsvd_31_13;
        logic [1:0]  mpp;         // Previous privilege, machine only
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

    typedef struct packed {
        logic        intr;        // Set for interrupts
        logic [30:0] cause;
    } mcause_fields_t;

    // Raw word on CSR writes, flag plus cause on trap entry
    typedef union packed {
        logic [XLEN-1:0] raw;
        mcause_fields_t  fields;
    } mcause_u;

endpackage

/* verilog/csr_bus_if.sv */
// Dispatch to hart access bus
`timescale 1ns/1ps

interface csr_bus_if import secv_pkg::*, csr_pkg::*; ();

    logic            strb;    // One-cycle access strobe
    logic            phase;   // Answer cycle, same on every hart
    csr_op_t         op;
    csr_adr_t        adr;     // Low 4 bits give the trap cause
    logic [XLEN-1:0] wdat;
    logic [XLEN-1:0] arg;     // Trap PC
    logic [XLEN-1:0] tval;
    logic [XLEN-1:0] rdat;    // Answer from old state

    modport src (
        output strb, phase, op, adr, wdat, arg, tval
    );

    modport hart (
        input  strb, op, adr, wdat, arg, tval,
        output rdat
    );

    modport sink (
        input  strb, phase, rdat
    );

endinterface

/* verilog/csr_dispatch.sv */
// Request slave and hart dispatch
`timescale 1ns/1ps

module csr_dispatch import secv_pkg::*, csr_pkg::*; #(
    parameter  int HARTS  = 4,
    localparam int HART_W = $clog2(HARTS + 1)
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_i,
    input  logic [HART_W-1:0] hart_i,
    input  csr_op_t           op_i,
    input  csr_adr_t          adr_i,
    input  logic [XLEN-1:0]   wdat_i,
    input  logic [XLEN-1:0]   arg_i,
    input  logic [XLEN-1:0]   tval_i,
    csr_bus_if.src            bus_o [HARTS]
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STRB,
        ST_WAIT
    } state_t;

    state_t            state_q;
    logic [HARTS-1:0]  strb_q;
    logic [HARTS-1:0]  sel_d;
    logic              phase_q;

    // Latched request
    logic [HART_W-1:0] hart_q;
    csr_op_t           op_q;
    csr_adr_t          adr_q;
    logic [XLEN-1:0]   wdat_q;
    logic [XLEN-1:0]   arg_q;
    logic [XLEN-1:0]   tval_q;

    // One-hot hart select, all zero when out of range
    always_comb begin : hart_decode
        for (int h = 0; h < HARTS; h++) begin
            sel_d[h] = (int'(hart_q) == h);
        end
    end

    always_ff @(posedge clk_i) begin : fsm
        if (rst_i) begin
            state_q <= ST_IDLE;
            strb_q  <= '0;
            phase_q <= 1'b0;
        end else begin
            strb_q  <= '0;                  // Strobe lasts one cycle
            phase_q <= 1'b0;
            case (state_q)
                ST_IDLE: if (req_i) state_q <= ST_STRB;
                ST_STRB: begin
                    strb_q  <= sel_d;
                    phase_q <= 1'b1;
                    state_q <= ST_WAIT;
                end
                ST_WAIT: if (!req_i) state_q <= ST_IDLE;  // Release with ack
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin : req_latch
        if (state_q == ST_IDLE && req_i) begin
            hart_q <= hart_i;
            op_q   <= op_i;
            adr_q  <= adr_i;
            wdat_q <= wdat_i;
            arg_q  <= arg_i;
            tval_q <= tval_i;
        end
    end

    // Payload is shared, only the strobe is per hart
    for (genvar h = 0; h < HARTS; h++) begin : g_bus
        assign bus_o[h].strb  = strb_q[h];
        assign bus_o[h].phase = phase_q;
        assign bus_o[h].op    = op_q;
        assign bus_o[h].adr   = adr_q;
        assign bus_o[h].wdat  = wdat_q;
        assign bus_o[h].arg   = arg_q;
        assign bus_o[h].tval  = tval_q;
    end

endmodule

/* verilog/csr_regs.sv */
// Machine CSR file for one hart
`timescale 1ns/1ps

module csr_regs import secv_pkg::*, csr_pkg::*; #(
    parameter int HART_ID = 0
) (
    input  logic    clk_i,
    input  logic    rst_i,
    csr_bus_if.hart bus
);

    // Trap setup
    mstatus_t        mstatus_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mtvec_q;      // Bit 0 selects vectored mode

    // Trap handling
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    mcause_u         mcause_q;
    logic [XLEN-1:0] mtval_q;

    ex_cause_t       ex_cause;
    intr_cause_t     intr_cause;
    mcause_u         trap_cause;
    logic            tval_valid;
    logic [XLEN-1:0] mtvec_base;
    mstatus_t        mstatus_rd;
    logic [XLEN-1:0] csr_rd;

    // Cause travels in the address field on traps
    assign ex_cause   = ex_cause_t'(bus.adr[3:0]);
    assign intr_cause = intr_cause_t'(bus.adr[3:0]);
    assign mtvec_base = {mtvec_q[XLEN-1:2], 2'b00};

    always_comb begin : trap_cause_build
        trap_cause              = '0;
        trap_cause.fields.intr  = (bus.op == OP_INTERRUPT);
        trap_cause.fields.cause = 31'(bus.adr[3:0]);
    end

    // Faulting address only for load and store faults
    always_comb begin : tval_select
        tval_valid = 1'b0;
        if (bus.op == OP_EXCEPTION) begin
            case (ex_cause)
                EX_CAUSE_LOAD_MISALIGNED,
                EX_CAUSE_LOAD_ACCESS_FAULT,
                EX_CAUSE_STORE_MISALIGNED,
                EX_CAUSE_STORE_ACCESS_FAULT: tval_valid = 1'b1;
                default:                     tval_valid = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin : reg_update
        if (rst_i) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else if (bus.strb) begin
            case (bus.op)
                OP_EXCEPTION, OP_INTERRUPT: begin
                    mepc_q         <= bus.arg;
                    mcause_q       <= trap_cause;
                    mtval_q        <= tval_valid ? bus.tval : '0;
                    mstatus_q.mpie <= mstatus_q.mie;
                    mstatus_q.mie  <= 1'b0;          // Handler runs with interrupts off
                end
                OP_MRET: begin
                    mstatus_q.mie  <= mstatus_q.mpie;
                    mstatus_q.mpie <= 1'b1;
                end
                OP_WRITE: begin
                    case (bus.adr)
                        CSR_ADR_MSTATUS:
                            mstatus_q <= mstatus_t'((mstatus_q & ~MSTATUS_MASK) |
                                                    (bus.wdat & MSTATUS_MASK));
                        CSR_ADR_MIE:      mie_q        <= bus.wdat & MIE_MASK;
                        CSR_ADR_MTVEC:    mtvec_q      <= bus.wdat & MTVEC_MASK;
                        CSR_ADR_MSCRATCH: mscratch_q   <= bus.wdat;
                        CSR_ADR_MEPC:     mepc_q       <= bus.wdat;
                        CSR_ADR_MCAUSE:   mcause_q.raw <= bus.wdat;
                        CSR_ADR_MTVAL:    mtval_q      <= bus.wdat;
                        default: ;                   // Read-only or unknown
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_comb begin : mstatus_view
        mstatus_rd     = mstatus_q;
        mstatus_rd.mpp = MSTATUS_MPP_M;      // Machine mode only
    end

    always_comb begin : csr_read
        case (bus.adr)
            CSR_ADR_MSTATUS:   csr_rd = mstatus_rd;
            CSR_ADR_MISA:      csr_rd = MISA_VALUE;
            CSR_ADR_MIE:       csr_rd = mie_q;
            CSR_ADR_MTVEC:     csr_rd = mtvec_q;
            CSR_ADR_MSCRATCH:  csr_rd = mscratch_q;
            CSR_ADR_MEPC:      csr_rd = mepc_q;
            CSR_ADR_MCAUSE:    csr_rd = mcause_q.raw;
            CSR_ADR_MTVAL:     csr_rd = mtval_q;
            CSR_ADR_MVENDORID: csr_rd = MVENDORID;
            CSR_ADR_MARCHID:   csr_rd = MARCHID;
            CSR_ADR_MIMPID:    csr_rd = MIMPID;
            CSR_ADR_MHARTID:   csr_rd = XLEN'(HART_ID);
            default:           csr_rd = '0;
        endcase
    end

    // Answer always comes from the state before the update
    always_comb begin : answer_mux
        case (bus.op)
            OP_READ, OP_WRITE: bus.rdat = csr_rd;
            OP_EXCEPTION:      bus.rdat = mtvec_base;
            OP_INTERRUPT: begin
                if (mtvec_q[0])
                    bus.rdat = mtvec_base + (XLEN'(intr_cause) << 2);  // Vectored
                else
                    bus.rdat = mtvec_base;
            end
            OP_MRET:           bus.rdat = mepc_q;
            default:           bus.rdat = '0;
        endcase
    end

endmodule

/* verilog/csr_return.sv */
// Answer collection and ack
`timescale 1ns/1ps

module csr_return import secv_pkg::*; #(
    parameter int HARTS = 4
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            req_i,
    csr_bus_if.sink         bus_i [HARTS],
    output logic            ack_o,
    output logic [XLEN-1:0] rdat_o
);

    logic [XLEN-1:0] hart_dat [HARTS];
    logic [XLEN-1:0] sel_dat;
    logic            phase;

    assign phase = bus_i[0].phase;   // Driven alike on all harts

    // Only the strobed hart contributes
    for (genvar h = 0; h < HARTS; h++) begin : g_gate
        assign hart_dat[h] = bus_i[h].strb ? bus_i[h].rdat : '0;
    end

    always_comb begin : or_reduce
        sel_dat = '0;
        for (int h = 0; h < HARTS; h++) begin
            sel_dat = sel_dat | hart_dat[h];
        end
    end

    // No hart strobed gives zero on an out-of-range request
    always_ff @(posedge clk_i) begin : ack_ctrl
        if (rst_i) begin
            ack_o  <= 1'b0;
            rdat_o <= '0;
        end else if (phase) begin
            ack_o  <= 1'b1;
            rdat_o <= sel_dat;
        end else if (!req_i) begin
            ack_o  <= 1'b0;
        end
    end

endmodule

/* verilog/csr_cluster.sv */
// Multi-hart machine CSR cluster
`timescale 1ns/1ps

module csr_cluster import secv_pkg::*, csr_pkg::*; #(
    parameter  int HARTS  = 4,
    localparam int HART_W = $clog2(HARTS + 1)
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_i,
    input  logic [HART_W-1:0] hart_i,   // Values of HARTS and up are answered with zero
    input  csr_op_t           op_i,
    input  csr_adr_t          adr_i,
    input  logic [XLEN-1:0]   wdat_i,
    input  logic [XLEN-1:0]   arg_i,
    input  logic [XLEN-1:0]   tval_i,
    output logic              ack_o,
    output logic [XLEN-1:0]   rdat_o
);

    csr_bus_if bus [HARTS] ();

    csr_dispatch #(
        .HARTS (HARTS)
    ) csr_dispatch_inst (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .req_i  (req_i),
        .hart_i (hart_i),
        .op_i   (op_i),
        .adr_i  (adr_i),
        .wdat_i (wdat_i),
        .arg_i  (arg_i),
        .tval_i (tval_i),
        .bus_o  (bus)
    );

    // One register file per hart
    for (genvar h = 0; h < HARTS; h++) begin : g_hart
        csr_regs #(
            .HART_ID (h)
        ) csr_regs_inst (
            .clk_i (clk_i),
            .rst_i (rst_i),
            .bus   (bus[h])
        );
    end

    csr_return #(
        .HARTS (HARTS)
    ) csr_return_inst (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .req_i  (req_i),
        .bus_i  (bus),
        .ack_o  (ack_o),
        .rdat_o (rdat_o)
    );

endmodule

/* bench/tb_csr_cluster.sv */
// CSR cluster testbench
`timescale 1ns/1ps

module tb_csr_cluster import secv_pkg::*, csr_pkg::*; ();

    localparam int HARTS = 4;
    localparam int N_RAND = 160;
    localparam int N_TRAP = 24;
    localparam int N_BAD = 8;
    localparam int N_TXN = 3 * HARTS * 12 + N_RAND + N_TRAP * 9 + N_BAD;
    localparam int CYCLE_LIMIT = 40 * N_TXN + 100;

    // Twelve CSRs plus one unmapped address
    localparam logic [11:0] ADR_LIST [13] = '{
        CSR_ADR_MSTATUS, CSR_ADR_MISA, CSR_ADR_MIE, CSR_ADR_MTVEC, CSR_ADR_MSCRATCH,
        CSR_ADR_MEPC, CSR_ADR_MCAUSE, CSR_ADR_MTVAL, CSR_ADR_MVENDORID, CSR_ADR_MARCHID,
        CSR_ADR_MIMPID, CSR_ADR_MHARTID, 12'h7C0
    };
    localparam logic [3:0] EX_LIST [8] = '{
        EX_CAUSE_INSTR_MISALIGNED, EX_CAUSE_ILLEGAL_INSTR, EX_CAUSE_BREAKPOINT,
        EX_CAUSE_LOAD_MISALIGNED, EX_CAUSE_LOAD_ACCESS_FAULT, EX_CAUSE_STORE_MISALIGNED,
        EX_CAUSE_STORE_ACCESS_FAULT, EX_CAUSE_ECALL_M
    };
    localparam logic [3:0] INT_LIST [3] = '{
        INTR_CAUSE_SOFTWARE, INTR_CAUSE_TIMER, INTR_CAUSE_EXTERNAL
    };

    logic        clk_i;
    logic        rst_i;
    logic        req_i;
    logic [2:0]  hart_i;
    csr_op_t     op_i;
    logic [11:0] adr_i;
    logic [31:0] wdat_i;
    logic [31:0] arg_i;
    logic [31:0] tval_i;
    logic        ack_o;
    logic [31:0] rdat_o;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] seed = 32'd8003;
    logic        ack_seen = 1'b0;
    logic [31:0] exp_q [$];                   // Expected answers in request order
    string       what_q [$];

    // Model state, MIE and MPIE only in m_status
    logic [31:0] m_status [HARTS];
    logic [31:0] m_ie [HARTS];
    logic [31:0] m_tvec [HARTS];
    logic [31:0] m_scratch [HARTS];
    logic [31:0] m_epc [HARTS];
    logic [31:0] m_cause [HARTS];
    logic [31:0] m_tval [HARTS];

    csr_cluster #(
        .HARTS (HARTS)
    ) csr_cluster_inst (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .req_i  (req_i),
        .hart_i (hart_i),
        .op_i   (op_i),
        .adr_i  (adr_i),
        .wdat_i (wdat_i),
        .arg_i  (arg_i),
        .tval_i (tval_i),
        .ack_o  (ack_o),
        .rdat_o (rdat_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function logic [31:0] read_ref(input int h, input logic [11:0] adr);
        case (adr)
            CSR_ADR_MSTATUS:   return m_status[h] | 32'h0000_1800;  // MPP reads as 3
            CSR_ADR_MISA:      return MISA_VALUE;
            CSR_ADR_MIE:       return m_ie[h];
            CSR_ADR_MTVEC:     return m_tvec[h];
            CSR_ADR_MSCRATCH:  return m_scratch[h];
            CSR_ADR_MEPC:      return m_epc[h];
            CSR_ADR_MCAUSE:    return m_cause[h];
            CSR_ADR_MTVAL:     return m_tval[h];
            CSR_ADR_MVENDORID: return MVENDORID;
            CSR_ADR_MARCHID:   return MARCHID;
            CSR_ADR_MIMPID:    return MIMPID;
            CSR_ADR_MHARTID:   return 32'(h);
            default:           return 32'h0;
        endcase
    endfunction

    // Expected answer, with the model updated as the hart would be
    function logic [31:0] ref_access(input int h, input csr_op_t op, input logic [11:0] adr,
                                     input logic [31:0] wdat, input logic [31:0] arg,
                                     input logic [31:0] tval);
        logic [31:0] base;
        logic [31:0] ans;
        logic [3:0]  cause;
        if (h >= HARTS)
            return 32'h0;                     // No hart answers
        base  = m_tvec[h] & 32'hFFFF_FFFC;
        cause = adr[3:0];
        ans   = 32'h0;
        case (op)
            OP_READ: ans = read_ref(h, adr);
            OP_WRITE: begin
                ans = read_ref(h, adr);       // Old value
                case (adr)
                    CSR_ADR_MSTATUS:
                        m_status[h] = (m_status[h] & ~MSTATUS_MASK) | (wdat & MSTATUS_MASK);
                    CSR_ADR_MIE:      m_ie[h] = wdat & MIE_MASK;
                    CSR_ADR_MTVEC:    m_tvec[h] = wdat & MTVEC_MASK;
                    CSR_ADR_MSCRATCH: m_scratch[h] = wdat;
                    CSR_ADR_MEPC:     m_epc[h] = wdat;
                    CSR_ADR_MCAUSE:   m_cause[h] = wdat;
                    CSR_ADR_MTVAL:    m_tval[h] = wdat;
                    default: ;
                endcase
            end
            OP_EXCEPTION, OP_INTERRUPT: begin
                ans = base;
                if (op == OP_INTERRUPT && m_tvec[h][0])
                    ans = base + {26'h0, cause, 2'b00};   // Vectored entry
                m_epc[h]   = arg;
                m_cause[h] = {op == OP_INTERRUPT, 27'h0, cause};
                m_tval[h]  = (op == OP_EXCEPTION && cause >= 4 && cause <= 7) ? tval : 32'h0;
                m_status[h] = {24'h0, m_status[h][3], 7'h0};  // MIE into MPIE
            end
            OP_MRET: begin
                ans = m_epc[h];
                m_status[h] = {24'h0, 1'b1, 3'b0, m_status[h][7], 3'b0};
            end
            default: ans = 32'h0;
        endcase
        return ans;
    endfunction

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // One four-phase transaction, entered and left 1 ns after a rising edge
    task automatic do_access(input logic [2:0] h, input csr_op_t op, input logic [11:0] adr,
                             input logic [31:0] wdat, input logic [31:0] arg,
                             input logic [31:0] tval, output logic [31:0] rdat);
        int lat;
        int hold;
        @(posedge clk_i);                     // One idle cycle with req low
        #1;
        check_val(32'(ack_o), 32'h0, "ack low while req low");
        exp_q.push_back(ref_access(int'(h), op, adr, wdat, arg, tval));
        what_q.push_back($sformatf("hart %0d op %0d adr %h", h, op, adr));
        hart_i = h;
        op_i   = op;
        adr_i  = adr;
        wdat_i = wdat;
        arg_i  = arg;
        tval_i = tval;
        req_i  = 1'b1;
        lat    = 0;
        while (!ack_o) begin
            @(posedge clk_i);
            #1;
            lat++;
        end
        check_val(32'(lat), 32'd3, "ack latency in edges");
        rdat = rdat_o;
        hold = int'(next_rand() % 3);
        repeat (hold) begin
            @(posedge clk_i);
            #1;
            check_val(32'(ack_o), 32'h1, "ack held while req high");
        end
        req_i = 1'b0;
        lat   = 0;
        while (ack_o) begin
            @(posedge clk_i);
            #1;
            lat++;
        end
        check_val(32'(lat), 32'd1, "ack release in edges");
    endtask

    task automatic scan_all();
        logic [31:0] rd;
        for (int h = 0; h < HARTS; h++)
            for (int i = 0; i < 12; i++)
                do_access(3'(h), OP_READ, ADR_LIST[i], 32'h0, 32'h0, 32'h0, rd);
    endtask

    // Compare at the falling edge where ack_o and rdat_o are settled
    always @(negedge clk_i) begin : compare_answers
        string what;
        if (ack_o && !ack_seen) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Ack seen at %0t ns with no request outstanding", $time);
            end else begin
                what = what_q.pop_front();
                check_val(rdat_o, exp_q.pop_front(), what);
            end
        end
        ack_seen = ack_o;
    end

    always @(posedge clk_i) begin : watchdog
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles, checks %0d, errors %0d",
                     cycles, checks, errors);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin : main
        logic [2:0]  h;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] t;
        logic [31:0] rd;
        logic [3:0]  cause;
        csr_op_t     op;
        for (int i = 0; i < HARTS; i++) begin
            m_status[i] = '0;
            m_ie[i] = '0;
            m_tvec[i] = '0;
            m_scratch[i] = '0;
            m_epc[i] = '0;
            m_cause[i] = '0;
            m_tval[i] = '0;
        end
        rst_i = 1'b1;
        req_i = 1'b0;
        hart_i = 3'h0;
        op_i = OP_READ;
        adr_i = 12'h0;
        wdat_i = 32'h0;
        arg_i = 32'h0;
        tval_i = 32'h0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        scan_all();                           // Reset values and identity
        for (int i = 0; i < N_RAND; i++) begin
            h  = 3'(next_rand() % 4);
            op = (next_rand() % 2 == 0) ? OP_WRITE : OP_READ;
            r  = next_rand();
            do_access(h, op, ADR_LIST[next_rand() % 13], r, 32'h0, 32'h0, rd);
        end
        scan_all();

        for (int i = 0; i < N_TRAP; i++) begin
            h = 3'(next_rand() % 4);
            do_access(h, OP_WRITE, CSR_ADR_MSTATUS, next_rand(), 32'h0, 32'h0, rd);
            r = next_rand();
            r[0] = i[0];                      // Alternate direct and vectored
            do_access(h, OP_WRITE, CSR_ADR_MTVEC, r, 32'h0, 32'h0, rd);
            op    = i[1] ? OP_INTERRUPT : OP_EXCEPTION;
            cause = i[1] ? INT_LIST[next_rand() % 3] : EX_LIST[next_rand() % 8];
            r = next_rand();
            a = next_rand();
            t = next_rand();
            do_access(h, op, {r[11:4], cause}, 32'h0, a, t, rd);
            do_access(h, OP_READ, CSR_ADR_MEPC, 32'h0, 32'h0, 32'h0, rd);
            do_access(h, OP_READ, CSR_ADR_MCAUSE, 32'h0, 32'h0, 32'h0, rd);
            do_access(h, OP_READ, CSR_ADR_MTVAL, 32'h0, 32'h0, 32'h0, rd);
            do_access(h, OP_READ, CSR_ADR_MSTATUS, 32'h0, 32'h0, 32'h0, rd);
            do_access(h, OP_MRET, 12'h0, 32'h0, 32'h0, 32'h0, rd);
            do_access(h, OP_READ, CSR_ADR_MSTATUS, 32'h0, 32'h0, 32'h0, rd);
        end

        // Out-of-range harts must leave every hart untouched
        for (int i = 0; i < N_BAD; i++) begin
            h  = 3'(4 + next_rand() % 4);
            op = i[0] ? OP_EXCEPTION : OP_WRITE;
            r  = next_rand();
            do_access(h, op, ADR_LIST[next_rand() % 8], r, r, r, rd);
        end
        scan_all();

        check_val(32'(exp_q.size()), 32'h0, "answers still outstanding");
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* sources.f */
verilog/secv_pkg.sv
verilog/csr_pkg.sv
verilog/csr_bus_if.sv
verilog/csr_dispatch.sv
verilog/csr_regs.sv
verilog/csr_return.sv
verilog/csr_cluster.sv
bench/tb_csr_cluster.sv

/* run.sh */
#!/usr/bin/env bash
# Build the CSR cluster testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_csr_cluster -f sources.f -o tb_csr_cluster \
    && ./obj_dir/tb_csr_cluster | tee /dev/stderr | grep -q "Regression passed" \
    && echo "Simulation OK" \
    || { echo "Simulation FAILED"; exit 1; }
